/* Bender.yml */
package:
  name: spdr

sources:
  - common/spdr_bus_pkg.sv
  - common/spdr_cmd_pkg.sv
  - src/spdr_hex_rx.sv
  - src/spdr_lane_align.sv
  - spdr_ctrl/spdr_ctrl.sv
  - src/spdr_hex_tx.sv
  - src/spdr_top.sv
  - target: test
    files:
      - test/tb_spdr.sv

/* common/spdr_bus_pkg.sv */
// Bus port types
package spdr_bus_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;

    typedef logic [DATA_W-1:0] word_t;

    // Same word seen whole, as byte lanes or as half lanes
    typedef union packed {
        word_t                       word;
        logic [DATA_W/8-1:0][7:0]    bytes;
        logic [DATA_W/16-1:0][15:0]  halves;
    } lanes_u;

    typedef struct packed {
        logic                wr;
        logic [DATA_W/8-1:0] mask;
        logic [ADDR_W-1:0]   addr;
        word_t               wdata;
    } bus_req_t;

endpackage

/* common/spdr_cmd_pkg.sv */
// Command and sequencer types
package spdr_cmd_pkg;

    localparam logic [7:0] CH_AT    = 8'h40;
    localparam logic [7:0] CH_HASH  = 8'h23;
    localparam logic [7:0] CH_EQ    = 8'h3D;
    localparam logic [7:0] CH_QUERY = 8'h3F;
    localparam logic [7:0] CH_PCT   = 8'h25;
    localparam logic [7:0] CH_SLASH = 8'h2F;
    localparam logic [7:0] CH_BANG  = 8'h21;
    localparam logic [7:0] CH_BS    = 8'h08;
    localparam logic [7:0] CH_CR    = 8'h0D;
    localparam logic [7:0] CH_LF    = 8'h0A;
    localparam logic [7:0] CH_DASH  = 8'h2D;
    localparam logic [7:0] CH_COLON = 8'h3A;

    typedef enum logic [1:0] {
        SIZE_W = 2'd0,
        SIZE_H = 2'd1,
        SIZE_B = 2'd2
    } size_mode_t;

    // One received character as seen by the sequencer
    typedef struct packed {
        logic [7:0]          byte_val;
        logic                is_num;
        logic                is_bs;
        spdr_bus_pkg::word_t number;
    } rx_char_t;

    typedef enum logic [1:0] {
        TX_LITERAL = 2'd0,
        TX_CAPTURE = 2'd1
    } tx_sel_t;

    typedef enum logic [4:0] {
        ST_IDLE,
        ST_ADDR,
        ST_SIZE,
        ST_WDATA,
        ST_GPO,
        ST_BUS_START,
        ST_BUS_WAIT,
        ST_GPI,
        ST_SEND_CAP,
        ST_SHOW_SIZE,
        ST_SHOW_DASH,
        ST_ERR_COLON,
        ST_ERR_E,
        ST_ERR_R1,
        ST_ERR_R2,
        ST_CR,
        ST_LF
    } state_t;

endpackage

/* spdr.f */
common/spdr_bus_pkg.sv
common/spdr_cmd_pkg.sv
src/spdr_hex_rx.sv
src/spdr_lane_align.sv
spdr_ctrl/spdr_ctrl.sv
src/spdr_hex_tx.sv
src/spdr_top.sv
test/tb_spdr.sv

/* spdr_ctrl/spdr_ctrl.sv */
// Command sequencer
module spdr_ctrl #(
    parameter int BUS_TIMEOUT = 256
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rx_valid,
    input  spdr_cmd_pkg::rx_char_t              rx,
    input  logic                                tx_ready,
    input  logic                                bus_ack,
    input  spdr_bus_pkg::word_t                 rdata_aligned,
    input  logic [spdr_bus_pkg::DATA_W/8-1:0]   mask,
    input  spdr_bus_pkg::word_t                 wdata_lanes,
    input  logic [2:0]                          step,
    input  spdr_bus_pkg::word_t                 gpi,
    output logic                                pop,
    output logic                                tx_push,
    output spdr_cmd_pkg::tx_sel_t               tx_sel,
    output logic [7:0]                          tx_literal,
    output logic                                capture_load,
    output spdr_bus_pkg::word_t                 capture_data,
    output logic [3:0]                          tx_digits,
    output spdr_cmd_pkg::size_mode_t            size_mode,
    output logic [1:0]                          addr_low,
    output spdr_bus_pkg::word_t                 wdata,
    output logic                                bus_req,
    output spdr_bus_pkg::bus_req_t              bus_cmd,
    output spdr_bus_pkg::word_t                 gpo,
    output logic                                gpo_strobe,
    output logic                                gpi_strobe
);

    localparam int TMR_W = $clog2(BUS_TIMEOUT + 1);

    spdr_cmd_pkg::state_t               state;
    spdr_cmd_pkg::state_t               next_state;
    logic [spdr_bus_pkg::ADDR_W-1:0]    addr;
    logic [TMR_W-1:0]                   timer;
    logic                               timeout;
    logic                               acc_wr;
    logic                               upd_addr;
    logic                               upd_size;
    logic                               upd_wdata;
    logic                               upd_gpo;
    logic                               cap_gpi;
    logic                               bus_start;
    logic                               bus_done;

    assign timeout = (timer == TMR_W'(BUS_TIMEOUT - 1));
    assign addr_low = addr[1:0];

    // Capture source follows the state that loads it
    always_comb
    begin
        tx_digits = 4'd8;
        if (state == spdr_cmd_pkg::ST_BUS_WAIT)
        begin
            capture_data = rdata_aligned;
            if (size_mode == spdr_cmd_pkg::SIZE_B)
                tx_digits = 4'd2;
            else if (size_mode == spdr_cmd_pkg::SIZE_H)
                tx_digits = 4'd4;
        end
        else if (state == spdr_cmd_pkg::ST_GPI)
            capture_data = gpi;
        else
            capture_data = addr;
    end

    always_comb
    begin
        next_state = state;
        pop = 1'b0;
        tx_push = 1'b0;
        tx_sel = spdr_cmd_pkg::TX_LITERAL;
        tx_literal = rx.byte_val;
        capture_load = 1'b0;
        upd_addr = 1'b0;
        upd_size = 1'b0;
        upd_wdata = 1'b0;
        upd_gpo = 1'b0;
        cap_gpi = 1'b0;
        bus_start = 1'b0;
        bus_done = 1'b0;

        case (state)
        spdr_cmd_pkg::ST_IDLE:
            if (rx_valid && tx_ready)
            begin
                pop = 1'b1;
                tx_push = 1'b1;
                case (rx.byte_val)
                spdr_cmd_pkg::CH_AT:    next_state = spdr_cmd_pkg::ST_ADDR;
                spdr_cmd_pkg::CH_HASH:  next_state = spdr_cmd_pkg::ST_SIZE;
                spdr_cmd_pkg::CH_EQ:    next_state = spdr_cmd_pkg::ST_WDATA;
                spdr_cmd_pkg::CH_QUERY: next_state = spdr_cmd_pkg::ST_BUS_START;
                spdr_cmd_pkg::CH_PCT:   next_state = spdr_cmd_pkg::ST_GPO;
                spdr_cmd_pkg::CH_SLASH: next_state = spdr_cmd_pkg::ST_GPI;
                spdr_cmd_pkg::CH_BANG:  next_state = spdr_cmd_pkg::ST_SHOW_SIZE;
                default:                tx_push = 1'b0;
                endcase
            end

        // Hex argument ended by any other character
        spdr_cmd_pkg::ST_ADDR, spdr_cmd_pkg::ST_WDATA, spdr_cmd_pkg::ST_GPO:
            if (rx_valid && tx_ready)
            begin
                pop = 1'b1;
                if (rx.is_num)
                    tx_push = 1'b1;
                else if (rx.is_bs)
                    next_state = spdr_cmd_pkg::ST_CR;
                else
                begin
                    upd_addr = (state == spdr_cmd_pkg::ST_ADDR);
                    upd_wdata = (state == spdr_cmd_pkg::ST_WDATA);
                    upd_gpo = (state == spdr_cmd_pkg::ST_GPO);
                    next_state = (state == spdr_cmd_pkg::ST_WDATA) ?
                                 spdr_cmd_pkg::ST_BUS_START : spdr_cmd_pkg::ST_CR;
                end
            end

        spdr_cmd_pkg::ST_SIZE:
            if (rx_valid && tx_ready)
            begin
                pop = 1'b1;
                tx_push = !rx.is_bs;
                upd_size = !rx.is_bs;
                next_state = spdr_cmd_pkg::ST_CR;
            end

        // Previous ack must be gone before a new request
        spdr_cmd_pkg::ST_BUS_START:
            if (!bus_ack)
            begin
                bus_start = 1'b1;
                next_state = spdr_cmd_pkg::ST_BUS_WAIT;
            end

        spdr_cmd_pkg::ST_BUS_WAIT:
            if (bus_ack)
            begin
                bus_done = 1'b1;
                capture_load = !acc_wr;
                next_state = acc_wr ? spdr_cmd_pkg::ST_CR : spdr_cmd_pkg::ST_SEND_CAP;
            end
            else if (timeout)
                next_state = spdr_cmd_pkg::ST_ERR_COLON;

        spdr_cmd_pkg::ST_GPI:
        begin
            capture_load = 1'b1;
            cap_gpi = 1'b1;
            next_state = spdr_cmd_pkg::ST_SEND_CAP;
        end

        spdr_cmd_pkg::ST_SEND_CAP:
            if (tx_ready)
            begin
                tx_push = 1'b1;
                tx_sel = spdr_cmd_pkg::TX_CAPTURE;
                next_state = spdr_cmd_pkg::ST_CR;
            end

        spdr_cmd_pkg::ST_SHOW_SIZE:
            if (tx_ready)
            begin
                tx_push = 1'b1;
                tx_literal = (size_mode == spdr_cmd_pkg::SIZE_B) ? "b" :
                             (size_mode == spdr_cmd_pkg::SIZE_H) ? "h" : "w";
                next_state = spdr_cmd_pkg::ST_SHOW_DASH;
            end

        spdr_cmd_pkg::ST_SHOW_DASH:
            if (tx_ready)
            begin
                tx_push = 1'b1;
                tx_literal = spdr_cmd_pkg::CH_DASH;
                capture_load = 1'b1;
                next_state = spdr_cmd_pkg::ST_SEND_CAP;
            end

        // Fixed text sent one character per handshake
        spdr_cmd_pkg::ST_ERR_COLON, spdr_cmd_pkg::ST_ERR_E, spdr_cmd_pkg::ST_ERR_R1,
        spdr_cmd_pkg::ST_ERR_R2, spdr_cmd_pkg::ST_CR, spdr_cmd_pkg::ST_LF:
            if (tx_ready)
            begin
                tx_push = 1'b1;
                case (state)
                spdr_cmd_pkg::ST_ERR_COLON: tx_literal = spdr_cmd_pkg::CH_COLON;
                spdr_cmd_pkg::ST_ERR_E:     tx_literal = "E";
                spdr_cmd_pkg::ST_CR:        tx_literal = spdr_cmd_pkg::CH_CR;
                spdr_cmd_pkg::ST_LF:        tx_literal = spdr_cmd_pkg::CH_LF;
                default:                    tx_literal = "r";
                endcase
                next_state = (state == spdr_cmd_pkg::ST_LF) ?
                             spdr_cmd_pkg::ST_IDLE : spdr_cmd_pkg::state_t'(state + 5'd1);
            end

        default: next_state = spdr_cmd_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= spdr_cmd_pkg::ST_IDLE;
            addr <= '0;
            size_mode <= spdr_cmd_pkg::SIZE_W;
            gpo <= '0;
            gpo_strobe <= 1'b0;
            gpi_strobe <= 1'b0;
            acc_wr <= 1'b0;
            bus_req <= 1'b0;
            timer <= '0;
        end
        else
        begin
            state <= next_state;
            gpo_strobe <= upd_gpo;
            gpi_strobe <= cap_gpi;

            if (upd_addr)
                addr <= rx.number;
            else if (bus_done)
                addr <= addr + spdr_bus_pkg::ADDR_W'(step);

            if (upd_size)
                size_mode <= (rx.byte_val == "b") ? spdr_cmd_pkg::SIZE_B :
                             (rx.byte_val == "h") ? spdr_cmd_pkg::SIZE_H : spdr_cmd_pkg::SIZE_W;

            if (upd_gpo)
                gpo <= rx.number;

            if (upd_wdata)
                acc_wr <= 1'b1;
            else if (state == spdr_cmd_pkg::ST_IDLE)
                acc_wr <= 1'b0;

            if (bus_start)
            begin
                bus_req <= 1'b1;
                timer <= '0;
            end
            else if (state == spdr_cmd_pkg::ST_BUS_WAIT)
            begin
                timer <= timer + 1'b1;
                if (bus_ack || timeout)
                    bus_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (upd_wdata)
            wdata <= rx.number;
        if (bus_start)
            bus_cmd <= '{wr: acc_wr, mask: mask, addr: addr,
                         wdata: acc_wr ? wdata_lanes : '0};
    end

endmodule

/* src/spdr_hex_rx.sv */
// Input character decoder
module spdr_hex_rx (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_req,
    input  logic [7:0]              in_char,
    input  logic                    pop,
    output logic                    in_ack,
    output logic                    rx_valid,
    output spdr_cmd_pkg::rx_char_t  rx
);

    logic [3:0]          digit;
    logic                is_num;
    spdr_bus_pkg::word_t arg;

    // Hex digit in either case
    always_comb
    begin
        digit = 4'd0;
        is_num = 1'b1;
        if (in_char >= "0" && in_char <= "9")
            digit = in_char[3:0];
        else if ((in_char >= "A" && in_char <= "F") || (in_char >= "a" && in_char <= "f"))
            digit = in_char[3:0] + 4'd9;
        else
            is_num = 1'b0;
    end

    assign rx_valid = in_req && !in_ack;

    assign rx.byte_val = in_char;
    assign rx.is_num = is_num;
    assign rx.is_bs = (in_char == spdr_cmd_pkg::CH_BS);
    assign rx.number = arg;

    // Ack holds until the sender drops req
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            in_ack <= 1'b0;
        else if (pop)
            in_ack <= 1'b1;
        else if (!in_req)
            in_ack <= 1'b0;
    end

    // Leading digits beyond eight fall off the top
    always_ff @(posedge clk)
    begin
        if (pop)
            arg <= is_num ? {arg[spdr_bus_pkg::DATA_W-5:0], digit} : '0;
    end

endmodule

/* src/spdr_hex_tx.sv */
// Output character sender
module spdr_hex_tx (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tx_push,
    input  spdr_cmd_pkg::tx_sel_t   tx_sel,
    input  logic [7:0]              tx_literal,
    input  logic                    capture_load,
    input  spdr_bus_pkg::word_t     capture_data,
    input  logic [3:0]              tx_digits,
    input  logic                    out_ack,
    output logic                    tx_ready,
    output logic                    out_req,
    output logic [7:0]              out_char
);

    spdr_bus_pkg::word_t cap;
    logic [3:0]          cap_cnt;
    logic [3:0]          left;
    logic                wait_low;
    logic                send_digit;

    function automatic logic [7:0] hex_char(input logic [3:0] nib);
        return (nib < 4'd10) ? (8'h30 + 8'(nib)) : (8'h37 + 8'(nib));
    endfunction

    assign tx_ready = !out_req && !wait_low;

    // First digit of a capture, or the next one once ack has dropped
    assign send_digit = (tx_push && tx_sel == spdr_cmd_pkg::TX_CAPTURE) ||
                        (wait_low && !out_ack && left != 4'd0);

    // Digits kept left aligned so the next one always sits in the top nibble
    always_ff @(posedge clk)
    begin
        if (capture_load)
        begin
            cap <= capture_data << {4'd8 - tx_digits, 2'b00};
            cap_cnt <= tx_digits;
        end
        else if (send_digit)
            cap <= cap << 4;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            out_req <= 1'b0;
            out_char <= 8'd0;
            wait_low <= 1'b0;
            left <= 4'd0;
        end
        else if (out_req)
        begin
            if (out_ack)
            begin
                out_req <= 1'b0;
                wait_low <= 1'b1;
            end
        end
        else if (send_digit)
        begin
            out_req <= 1'b1;
            wait_low <= 1'b0;
            out_char <= hex_char(cap[spdr_bus_pkg::DATA_W-1 -: 4]);
            left <= (wait_low ? left : cap_cnt) - 4'd1;
        end
        else if (wait_low)
        begin
            if (!out_ack)
                wait_low <= 1'b0;
        end
        else if (tx_push)
        begin
            out_req <= 1'b1;
            out_char <= tx_literal;
            left <= 4'd0;
        end
    end

endmodule

/* src/spdr_lane_align.sv */
// Sub-word lane alignment
module spdr_lane_align (
    input  spdr_cmd_pkg::size_mode_t                size_mode,
    input  logic [1:0]                              addr_low,
    input  spdr_bus_pkg::word_t                     wdata,
    input  spdr_bus_pkg::word_t                     rsp_data,
    output logic [spdr_bus_pkg::DATA_W/8-1:0]       mask,
    output spdr_bus_pkg::word_t                     wdata_lanes,
    output spdr_bus_pkg::word_t                     rdata_aligned,
    output logic [2:0]                              step
);

    spdr_bus_pkg::lanes_u wr_lanes;
    spdr_bus_pkg::lanes_u rsp_lanes;

    assign wr_lanes = wdata;
    assign rsp_lanes = rsp_data;

    always_comb
    begin
        case (size_mode)
        spdr_cmd_pkg::SIZE_B:
        begin
            mask = 4'b0001 << addr_low;
            wdata_lanes = {4{wr_lanes.bytes[0]}};
            rdata_aligned = spdr_bus_pkg::word_t'(rsp_lanes.bytes[addr_low]);
            step = 3'd1;
        end
        spdr_cmd_pkg::SIZE_H:
        begin
            mask = addr_low[1] ? 4'b1100 : 4'b0011;
            wdata_lanes = {2{wr_lanes.halves[0]}};
            rdata_aligned = spdr_bus_pkg::word_t'(rsp_lanes.halves[addr_low[1]]);
            step = 3'd2;
        end
        default:
        begin
            mask = 4'b1111;
            wdata_lanes = wr_lanes.word;
            rdata_aligned = rsp_lanes.word;
            step = 3'd4;
        end
        endcase
    end

endmodule

/* src/spdr_top.sv */
// Serial port bus debugger
module spdr_top #(
    parameter int BUS_TIMEOUT = 256
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_req,
    input  logic [7:0]              in_char,
    input  logic                    out_ack,
    input  logic                    bus_ack,
    input  spdr_bus_pkg::word_t     bus_rdata,
    input  spdr_bus_pkg::word_t     gpi,
    output logic                    in_ack,
    output logic                    out_req,
    output logic [7:0]              out_char,
    output logic                    bus_req,
    output spdr_bus_pkg::bus_req_t  bus_cmd,
    output spdr_bus_pkg::word_t     gpo,
    output logic                    gpo_strobe,
    output logic                    gpi_strobe
);

    logic                               pop;
    logic                               rx_valid;
    spdr_cmd_pkg::rx_char_t             rx;
    logic                               tx_ready;
    logic                               tx_push;
    spdr_cmd_pkg::tx_sel_t              tx_sel;
    logic [7:0]                         tx_literal;
    logic                               capture_load;
    spdr_bus_pkg::word_t                capture_data;
    logic [3:0]                         tx_digits;
    spdr_cmd_pkg::size_mode_t           size_mode;
    logic [1:0]                         addr_low;
    spdr_bus_pkg::word_t                wdata;
    logic [spdr_bus_pkg::DATA_W/8-1:0]  mask;
    spdr_bus_pkg::word_t                wdata_lanes;
    spdr_bus_pkg::word_t                rdata_aligned;
    logic [2:0]                         step;

    spdr_hex_rx u_hex_rx (.*);

    spdr_ctrl #(
        .BUS_TIMEOUT(BUS_TIMEOUT)
    ) u_ctrl (.*);

    spdr_lane_align u_lane_align (
        .rsp_data(bus_rdata),
        .*
    );

    spdr_hex_tx u_hex_tx (.*);

endmodule

/* test/tb_spdr.sv */
// Serial port debugger testbench
module tb_spdr;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BUS_TIMEOUT = 64;
    localparam int WAIT_LIMIT = 400;

    typedef struct {
        string                  stim;
        string                  resp;
        bit                     has_bus;
        spdr_bus_pkg::bus_req_t bus;
        spdr_bus_pkg::word_t    gpo;
        spdr_bus_pkg::word_t    gpi;
        bit                     silent;
    } row_t;

    logic                   clk;
    logic                   rst = 1'b1;
    logic                   in_req = 1'b0;
    logic [7:0]             in_char = 8'd0;
    logic                   out_ack = 1'b0;
    logic                   bus_ack = 1'b0;
    spdr_bus_pkg::word_t    bus_rdata = '0;
    spdr_bus_pkg::word_t    gpi = '0;
    logic                   in_ack;
    logic                   out_req;
    logic [7:0]             out_char;
    logic                   bus_req;
    spdr_bus_pkg::bus_req_t bus_cmd;
    spdr_bus_pkg::word_t    gpo;
    logic                   gpo_strobe;
    logic                   gpi_strobe;

    row_t                   rows[$];
    logic [7:0]             out_q[$];
    spdr_bus_pkg::bus_req_t bus_q[$];
    spdr_bus_pkg::word_t    mem[256];
    logic                   mem_silent = 1'b0;
    int                     mem_delay = 0;
    int                     ack_delay = 0;
    logic                   bus_req_d = 1'b0;
    int                     gpo_pulses = 0;
    int                     gpi_pulses = 0;
    int                     checks = 0;
    int                     errors = 0;
    logic                   hung = 1'b0;

    spdr_top #(
        .BUS_TIMEOUT(BUS_TIMEOUT)
    ) uut (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Console side acks each output character after a short random delay
    always @(posedge clk)
    begin
        if (out_ack)
        begin
            if (!out_req)
                out_ack <= 1'b0;
        end
        else if (ack_delay > 1)
            ack_delay <= ack_delay - 1;
        else if (ack_delay == 1)
        begin
            ack_delay <= 0;
            out_ack <= 1'b1;
            out_q.push_back(out_char);
        end
        else if (out_req)
            ack_delay <= 1 + ($urandom % 4);
    end

    // Word memory with byte enables that answers 1 to 6 cycles after req
    always @(posedge clk)
    begin : memory_model
        spdr_bus_pkg::lanes_u cur;
        spdr_bus_pkg::lanes_u wr;
        cur = mem[bus_cmd.addr[9:2]];
        wr = bus_cmd.wdata;
        if (bus_ack)
        begin
            if (!bus_req)
                bus_ack <= 1'b0;
        end
        else if (mem_delay > 1)
            mem_delay <= mem_delay - 1;
        else if (mem_delay == 1)
        begin
            mem_delay <= 0;
            bus_ack <= 1'b1;
            if (bus_cmd.wr)
            begin
                for (int i = 0; i < 4; i++)
                    if (bus_cmd.mask[i])
                        cur.bytes[i] = wr.bytes[i];
                mem[bus_cmd.addr[9:2]] = cur.word;
            end
            else
                bus_rdata <= cur.word;
        end
        else if (bus_req && !mem_silent)
            mem_delay <= 1 + ($urandom % 6);
    end

    // Records each new bus request and counts the strobes
    always @(posedge clk)
    begin
        bus_req_d <= bus_req;
        if (bus_req && !bus_req_d)
            bus_q.push_back(bus_cmd);
        if (gpo_strobe)
            gpo_pulses <= gpo_pulses + 1;
        if (gpi_strobe)
            gpi_pulses <= gpi_pulses + 1;
    end

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_char(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t %s: got 0x%02h expected 0x%02h", $time, name, got, exp);
        end
    endtask

    task automatic check_bus(input string name, input spdr_bus_pkg::bus_req_t got,
                             input spdr_bus_pkg::bus_req_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input spdr_bus_pkg::word_t got,
                              input spdr_bus_pkg::word_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("ERR %0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        if (!hung)
            $display("Timeout at %0t: %s", $time, what);
        hung = 1'b1;
    endtask

    task automatic send_char(input logic [7:0] c);
        int cycles;
        cycles = 0;
        @(posedge clk);
        in_char <= c;
        in_req <= 1'b1;
        while (!in_ack && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!in_ack)
            note_timeout("input character was never acknowledged");
        in_req <= 1'b0;
        cycles = 0;
        while (in_ack && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (in_ack)
            note_timeout("in_ack stayed high after req fell");
    endtask

    task automatic wait_output(output logic [7:0] c);
        int cycles;
        cycles = 0;
        c = 8'd0;
        while (out_q.size() == 0 && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (out_q.size() == 0)
            note_timeout("expected output character never arrived");
        else
            c = out_q.pop_front();
    endtask

    function automatic spdr_bus_pkg::bus_req_t bus_txn(input logic wr, input logic [3:0] mask,
                                                       input logic [31:0] addr,
                                                       input spdr_bus_pkg::word_t wdata);
        spdr_bus_pkg::bus_req_t t;
        t.wr = wr;
        t.mask = mask;
        t.addr = addr;
        t.wdata = wdata;
        return t;
    endfunction

    function automatic void add_row(input string stim, input string resp, input bit has_bus,
                                    input spdr_bus_pkg::bus_req_t bus,
                                    input spdr_bus_pkg::word_t gpo_exp,
                                    input spdr_bus_pkg::word_t gpi_val, input bit silent);
        row_t row;
        row.stim = stim;
        row.resp = resp;
        row.has_bus = has_bus;
        row.bus = bus;
        row.gpo = gpo_exp;
        row.gpi = gpi_val;
        row.silent = silent;
        rows.push_back(row);
    endfunction

    // CR is \015, LF is \012 and backspace is \010
    function automatic void load_table();
        spdr_bus_pkg::bus_req_t none;
        none = '0;
        add_row("@10\015", "@10\015\012", 0, none, 0, 0, 0);
        add_row("=12345678\015", "=12345678\015\012", 1,
                bus_txn(1, 4'b1111, 32'h10, 32'h12345678), 0, 0, 0);
        add_row("@10\015", "@10\015\012", 0, none, 0, 0, 0);
        add_row("?", "?12345678\015\012", 1, bus_txn(0, 4'b1111, 32'h10, 0), 0, 0, 0);
        add_row("#b", "#b\015\012", 0, none, 0, 0, 0);
        add_row("@13\015", "@13\015\012", 0, none, 0, 0, 0);
        add_row("=AB\015", "=AB\015\012", 1, bus_txn(1, 4'b1000, 32'h13, 32'hABABABAB), 0, 0, 0);
        add_row("@13\015", "@13\015\012", 0, none, 0, 0, 0);
        add_row("?", "?AB\015\012", 1, bus_txn(0, 4'b1000, 32'h13, 0), 0, 0, 0);
        add_row("!", "!b-00000014\015\012", 0, none, 0, 0, 0);
        add_row("#h", "#h\015\012", 0, none, 0, 0, 0);
        add_row("@12\015", "@12\015\012", 0, none, 0, 0, 0);
        add_row("=beef\015", "=beef\015\012", 1,
                bus_txn(1, 4'b1100, 32'h12, 32'hBEEFBEEF), 0, 0, 0);
        add_row("@12\015", "@12\015\012", 0, none, 0, 0, 0);
        add_row("?", "?BEEF\015\012", 1, bus_txn(0, 4'b1100, 32'h12, 0), 0, 0, 0);
        add_row("%DEADBEEF\015", "%DEADBEEF\015\012", 0, none, 32'hDEADBEEF, 0, 0);
        add_row("/", "/0F1E2D3C\015\012", 0, none, 32'hDEADBEEF, 32'h0F1E2D3C, 0);
        add_row("#w", "#w\015\012", 0, none, 32'hDEADBEEF, 0, 0);
        add_row("@20\015", "@20\015\012", 0, none, 32'hDEADBEEF, 0, 0);
        add_row("?", "?:Err\015\012", 1, bus_txn(0, 4'b1111, 32'h20, 0), 32'hDEADBEEF, 0, 1);
        add_row("!", "!w-00000020\015\012", 0, none, 32'hDEADBEEF, 0, 0);
        add_row("@12\010", "@12\015\012", 0, none, 32'hDEADBEEF, 0, 0);
        add_row("!", "!w-00000020\015\012", 0, none, 32'hDEADBEEF, 0, 0);
        add_row("xyz\015", "", 0, none, 32'hDEADBEEF, 0, 0);
        add_row("!", "!w-00000020\015\012", 0, none, 32'hDEADBEEF, 0, 0);
    endfunction

    task automatic run_row(input int r);
        int               i;
        int               gpo_start;
        int               gpi_start;
        int               errors_start;
        logic [7:0]       c;
        spdr_bus_pkg::bus_req_t txn;
        gpo_start = gpo_pulses;
        gpi_start = gpi_pulses;
        errors_start = errors;
        mem_silent <= rows[r].silent;
        gpi <= rows[r].gpi;
        for (i = 0; i < rows[r].stim.len() && !hung; i++)
            send_char(rows[r].stim[i]);
        for (i = 0; i < rows[r].resp.len() && !hung; i++)
        begin
            wait_output(c);
            if (!hung)
                check_char("out_char", c, rows[r].resp[i]);
        end
        if (!hung)
        begin
            // Output is complete only after the bus access has ended
            if (rows[r].has_bus && bus_q.size() == 0)
            begin
                errors++;
                $display("Row %0d: the expected bus access never started", r);
            end
            else if (rows[r].has_bus)
            begin
                txn = bus_q.pop_front();
                check_bus("bus_cmd", txn, rows[r].bus);
            end
            if (bus_q.size() != 0)
            begin
                errors++;
                $display("Row %0d: %0d unexpected bus accesses", r, bus_q.size());
                bus_q.delete();
            end
            check_word("gpo", gpo, rows[r].gpo);
            check_count("gpo_strobe", gpo_pulses - gpo_start, (rows[r].stim[0] == "%") ? 1 : 0);
            check_count("gpi_strobe", gpi_pulses - gpi_start, (rows[r].stim[0] == "/") ? 1 : 0);
        end
        $display("Row %0d done with %0d errors", r, errors - errors_start);
    endtask

    initial
    begin
        int r;
        void'($urandom(63952));
        for (r = 0; r < 256; r++)
            mem[r] = 32'h9E3779B9 * (r + 1);
        load_table();
        repeat (8) @(posedge clk);
        // Outputs sit at their reset values before the first command
        check_flag("in_ack", in_ack, 1'b0);
        check_flag("out_req", out_req, 1'b0);
        check_flag("bus_req", bus_req, 1'b0);
        check_flag("gpo_strobe", gpo_strobe, 1'b0);
        check_flag("gpi_strobe", gpi_strobe, 1'b0);
        check_char("out_char", out_char, 8'd0);
        check_word("gpo", gpo, '0);
        rst <= 1'b0;
        for (r = 0; r < rows.size() && !hung; r++)
            run_row(r);
        if (!hung && out_q.size() != 0)
        begin
            errors++;
            $display("%0d output characters arrived after the last row", out_q.size());
        end
        $display("Rows %0d, checks %0d, errors %0d, timeouts %0d",
                 rows.size(), checks, errors, hung);
        if (errors == 0 && !hung)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule
